// File: files.f
+incdir+testbench
src/feature_pkg.sv
src/point_height_calc.sv
src/slice_counter.sv
src/slice_normalizer.sv
src/feature_store.sv
src/cluster_feature_extractor.sv
testbench/tb_cluster_feature_extractor.sv

// File: Bender.yml
package:
  name: cluster_feature_extractor

sources:
  - src/feature_pkg.sv
  - src/point_height_calc.sv
  - src/slice_counter.sv
  - src/slice_normalizer.sv
  - src/feature_store.sv
  - src/cluster_feature_extractor.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cluster_feature_extractor.sv

// File: testbench/tb_feature_checks.svh
`ifndef TB_FEATURE_CHECKS_SVH
`define TB_FEATURE_CHECKS_SVH

// reference height of one point in s6c9f
function automatic feature_pkg::fixed_t height_of_point(
    feature_pkg::feature_t dist_code,
    feature_pkg::laser_t   laser_idx
);
    int scaled;
    int metres;
    int product;
    // code times 0.002 m, 16 fraction bits
    scaled = int'(dist_code) * int'(feature_pkg::DIST_SCALE);
    // bits 21..6 give metres with 10 fraction bits
    metres = (scaled / 64) % 65536;
    product = metres * int'(feature_pkg::SIN_THETA[laser_idx]);
    // bits 26..11 of the product, floor for negative heights
    return feature_pkg::fixed_t'(product >>> 11);
endfunction

// slice index of a point, -1 for ground or outside all slices
function automatic int slice_of_point(
    feature_pkg::fixed_t z_floor,
    feature_pkg::fixed_t z_point
);
    feature_pkg::fixed_t lower;
    feature_pkg::fixed_t upper;
    if (z_point <= feature_pkg::GROUND_LIMIT)
    begin
        return -1;
    end
    lower = z_floor;
    for (int k = 0; k < feature_pkg::SLICE_COUNT; k++)
    begin
        upper = z_floor + feature_pkg::SLICE_HEIGHT[k];
        // lower edge inclusive, upper edge exclusive
        if (z_point >= lower && z_point < upper)
        begin
            return k;
        end
        lower = upper;
    end
    return -1;
endfunction

// count over total with 15 fraction bits, low 16 bits kept
function automatic feature_pkg::feature_t slice_ratio(
    feature_pkg::count_t count,
    feature_pkg::count_t total
);
    if (total == '0)
    begin
        return '0;
    end
    return feature_pkg::feature_t'((int'(count) << feature_pkg::RATIO_FRAC_BITS) / int'(total));
endfunction

task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first mismatch");
endtask

task automatic match_feature(
    string                 name,
    feature_pkg::feature_t got,
    feature_pkg::feature_t expected
);
    if (got !== expected)
    begin
        error_count++;
        $display("[ERROR] t=%0t %s: got 0x%04h, expected 0x%04h", $time, name, got, expected);
        abort_run();
    end
endtask

task automatic verify_beat_count(
    string               name,
    feature_pkg::count_t got,
    feature_pkg::count_t expected
);
    if (got !== expected)
    begin
        error_count++;
        $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
        abort_run();
    end
endtask

task automatic match_flag(string name, logic got, logic expected);
    if (got !== expected)
    begin
        error_count++;
        $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, expected);
        abort_run();
    end
endtask

`endif

// File: testbench/tb_cluster_feature_extractor.sv
module tb_cluster_feature_extractor;

    // eight random clusters, then one with a zero point count
    localparam int NUM_CLUSTERS = 9;
    localparam int MIN_POINTS = 20;
    localparam int MAX_POINTS = 60;
    localparam int CYCLE_LIMIT = NUM_CLUSTERS * (MAX_POINTS + 250);

    logic clk;
    logic flag_reset;
    logic flag_valid_header;
    feature_pkg::fixed_t z_min;
    feature_pkg::count_t num_points;
    feature_pkg::feature_t h_in;
    feature_pkg::feature_t w_in;
    feature_pkg::feature_t l_in;
    feature_pkg::feature_t num_points_norm_in;
    feature_pkg::feature_t mean_intensity_in;
    logic flag_new_points;
    feature_pkg::feature_t distance;
    feature_pkg::laser_t laser;
    feature_pkg::feature_t features;
    logic flag_valid_out;

    integer seed;
    int error_count = 0;
    int cycle_cnt = 0;
    // points of the cluster in flight
    feature_pkg::feature_t pt_distance [MAX_POINTS];
    feature_pkg::laser_t pt_laser [MAX_POINTS];

    `include "tb_feature_checks.svh"

    cluster_feature_extractor dut_i (
        .clk                (clk),
        .flag_reset         (flag_reset),
        .flag_valid_header  (flag_valid_header),
        .z_min              (z_min),
        .num_points         (num_points),
        .h_in               (h_in),
        .w_in               (w_in),
        .l_in               (l_in),
        .num_points_norm_in (num_points_norm_in),
        .mean_intensity_in  (mean_intensity_in),
        .flag_new_points    (flag_new_points),
        .distance           (distance),
        .laser              (laser),
        .features           (features),
        .flag_valid_out     (flag_valid_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop if a readout never shows up
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: no complete readout after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // mix of slice, ground, above-top and wild points
    task automatic make_points(int n);
        int category;
        for (int i = 0; i < n; i++)
        begin
            category = rand_range(0, 19);
            if (category < 12)
            begin
                // 5..20 m on upper lasers, mostly inside the slices
                pt_laser[i] = feature_pkg::laser_t'(rand_range(40, 63));
                pt_distance[i] = feature_pkg::feature_t'(rand_range(2500, 10000));
            end
            else if (category < 15)
            begin
                // steep lasers at 13..18 m, around the -6 m ground limit
                pt_laser[i] = feature_pkg::laser_t'(rand_range(0, 15));
                pt_distance[i] = feature_pkg::feature_t'(rand_range(6500, 9000));
            end
            else if (category < 18)
            begin
                // near level and close, above the top slice
                pt_laser[i] = feature_pkg::laser_t'(rand_range(58, 63));
                pt_distance[i] = feature_pkg::feature_t'(rand_range(500, 2500));
            end
            else
            begin
                pt_laser[i] = feature_pkg::laser_t'(rand_range(0, 63));
                pt_distance[i] = feature_pkg::feature_t'(rand_range(0, 32767));
            end
        end
    endtask

    task automatic run_cluster(bit zero_count, bit low_floor);
        int n;
        int slice;
        feature_pkg::fixed_t z_floor;
        feature_pkg::count_t total;
        feature_pkg::count_t model_counts [feature_pkg::SLICE_COUNT];
        feature_pkg::feature_t expected [feature_pkg::FEATURE_DEPTH];
        feature_pkg::feature_t beats [feature_pkg::FEATURE_DEPTH];
        feature_pkg::count_t beat_cnt;
        n = rand_range(MIN_POINTS, MAX_POINTS);
        make_points(n);
        // z_min between about -3.9 m and -2.1 m
        // or low enough that the bottom slices reach under the ground limit
        if (low_floor)
        begin
            z_floor = feature_pkg::fixed_t'(rand_range(-3600, -3100));
        end
        else
        begin
            z_floor = feature_pkg::fixed_t'(rand_range(-2000, -1100));
        end
        total = zero_count ? feature_pkg::count_t'(0) : feature_pkg::count_t'(n);
        for (int k = 0; k < feature_pkg::SLICE_COUNT; k++)
        begin
            model_counts[k] = '0;
        end
        for (int i = 0; i < n; i++)
        begin
            slice = slice_of_point(z_floor, height_of_point(pt_distance[i], pt_laser[i]));
            if (slice >= 0)
            begin
                model_counts[slice]++;
            end
        end

        // header, one cycle
        @(negedge clk);
        match_flag("flag_valid_out", flag_valid_out, 1'b0);
        flag_valid_header = 1'b1;
        z_min = z_floor;
        num_points = total;
        h_in = feature_pkg::feature_t'(rand_range(0, 65535));
        w_in = feature_pkg::feature_t'(rand_range(0, 65535));
        l_in = feature_pkg::feature_t'(rand_range(0, 65535));
        num_points_norm_in = feature_pkg::feature_t'(rand_range(0, 65535));
        mean_intensity_in = feature_pkg::feature_t'(rand_range(0, 65535));
        expected[feature_pkg::ADDR_HEIGHT] = h_in;
        expected[feature_pkg::ADDR_WIDTH] = w_in;
        expected[feature_pkg::ADDR_LENGTH] = l_in;
        expected[feature_pkg::ADDR_POINTS_NORM] = num_points_norm_in;
        expected[feature_pkg::ADDR_MEAN_INTENSITY] = mean_intensity_in;
        for (int k = 0; k < feature_pkg::SLICE_COUNT; k++)
        begin
            expected[feature_pkg::ADDR_SLICE_BASE + k] = slice_ratio(model_counts[k], total);
        end

        // one point per cycle
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            match_flag("flag_valid_out", flag_valid_out, 1'b0);
            flag_valid_header = 1'b0;
            flag_new_points = 1'b1;
            distance = pt_distance[i];
            laser = pt_laser[i];
        end
        @(negedge clk);
        match_flag("flag_valid_out", flag_valid_out, 1'b0);
        flag_new_points = 1'b0;

        // global cycle counter bounds this wait
        while (flag_valid_out !== 1'b1)
        begin
            @(negedge clk);
        end
        beat_cnt = '0;
        while (flag_valid_out === 1'b1 && beat_cnt < 20)
        begin
            if (beat_cnt < feature_pkg::FEATURE_DEPTH)
            begin
                beats[beat_cnt] = features;
            end
            beat_cnt++;
            @(negedge clk);
        end
        verify_beat_count("flag_valid_out beats", beat_cnt,
                          feature_pkg::count_t'(feature_pkg::FEATURE_DEPTH));
        for (int k = 0; k < feature_pkg::FEATURE_DEPTH; k++)
        begin
            match_feature($sformatf("features[%0d]", k), beats[k], expected[k]);
        end
    endtask

    initial
    begin
        seed = 32'h2660;
        flag_reset = 1'b1;
        flag_valid_header = 1'b0;
        z_min = '0;
        num_points = '0;
        h_in = '0;
        w_in = '0;
        l_in = '0;
        num_points_norm_in = '0;
        mean_intensity_in = '0;
        flag_new_points = 1'b0;
        distance = '0;
        laser = '0;
        repeat (8) @(negedge clk);
        flag_reset = 1'b0;
        // every other cluster puts its bottom slices under the ground limit
        for (int c = 0; c < NUM_CLUSTERS - 1; c++)
        begin
            run_cluster(1'b0, (c % 2) == 1);
        end
        // empty count, all ratios must read zero
        run_cluster(1'b1, 1'b0);
        if (error_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            abort_run();
        end
    end

endmodule

// File: src/cluster_feature_extractor.sv
module cluster_feature_extractor (
    input  logic                  clk,
    input  logic                  flag_reset,
    input  logic                  flag_valid_header,
    input  feature_pkg::fixed_t   z_min,
    input  feature_pkg::count_t   num_points,
    input  feature_pkg::feature_t h_in,
    input  feature_pkg::feature_t w_in,
    input  feature_pkg::feature_t l_in,
    input  feature_pkg::feature_t num_points_norm_in,
    input  feature_pkg::feature_t mean_intensity_in,
    input  logic                  flag_new_points,
    input  feature_pkg::feature_t distance,
    input  feature_pkg::laser_t   laser,
    output feature_pkg::feature_t features,
    output logic                  flag_valid_out
);

    // height pipeline to slice counter
    feature_pkg::fixed_t z;
    logic flag_point_valid;
    logic flag_points_done;
    // counter to divider
    feature_pkg::count_t slice_counts [feature_pkg::SLICE_COUNT];
    logic flag_counts_ready;
    // divider to feature memory
    logic slice_wr_en;
    feature_pkg::feature_addr_t slice_wr_addr;
    feature_pkg::feature_t slice_wr_data;
    logic flag_norm_done;

    point_height_calc height_i (
        .clk              (clk),
        .flag_reset       (flag_reset),
        .flag_new_points  (flag_new_points),
        .distance         (distance),
        .laser            (laser),
        .z                (z),
        .flag_point_valid (flag_point_valid),
        .flag_points_done (flag_points_done)
    );

    slice_counter counter_i (
        .clk               (clk),
        .flag_reset        (flag_reset),
        .flag_valid_header (flag_valid_header),
        .z_min             (z_min),
        .z                 (z),
        .flag_point_valid  (flag_point_valid),
        .flag_points_done  (flag_points_done),
        .flag_norm_done    (flag_norm_done),
        .slice_counts      (slice_counts),
        .flag_counts_ready (flag_counts_ready)
    );

    slice_normalizer normalizer_i (
        .clk               (clk),
        .flag_reset        (flag_reset),
        .flag_valid_header (flag_valid_header),
        .num_points        (num_points),
        .slice_counts      (slice_counts),
        .flag_counts_ready (flag_counts_ready),
        .slice_wr_en       (slice_wr_en),
        .slice_wr_addr     (slice_wr_addr),
        .slice_wr_data     (slice_wr_data),
        .flag_norm_done    (flag_norm_done)
    );

    feature_store store_i (
        .clk                (clk),
        .flag_reset         (flag_reset),
        .flag_valid_header  (flag_valid_header),
        .h_in               (h_in),
        .w_in               (w_in),
        .l_in               (l_in),
        .num_points_norm_in (num_points_norm_in),
        .mean_intensity_in  (mean_intensity_in),
        .slice_wr_en        (slice_wr_en),
        .slice_wr_addr      (slice_wr_addr),
        .slice_wr_data      (slice_wr_data),
        .flag_norm_done     (flag_norm_done),
        .features           (features),
        .flag_valid_out     (flag_valid_out)
    );

endmodule

// File: src/feature_store.sv
module feature_store (
    input  logic                       clk,
    input  logic                       flag_reset,
    input  logic                       flag_valid_header,
    input  feature_pkg::feature_t      h_in,
    input  feature_pkg::feature_t      w_in,
    input  feature_pkg::feature_t      l_in,
    input  feature_pkg::feature_t      num_points_norm_in,
    input  feature_pkg::feature_t      mean_intensity_in,
    input  logic                       slice_wr_en,
    input  feature_pkg::feature_addr_t slice_wr_addr,
    input  feature_pkg::feature_t      slice_wr_data,
    input  logic                       flag_norm_done,
    output feature_pkg::feature_t      features,
    output logic                       flag_valid_out
);

    feature_pkg::feature_t feature_mem [feature_pkg::FEATURE_DEPTH];
    // header scalars in write order
    feature_pkg::feature_t hdr_q [5];
    logic [2:0] hdr_cnt;
    logic hdr_busy;
    feature_pkg::feature_addr_t hdr_addr;
    logic wr_en;
    feature_pkg::feature_addr_t wr_addr;
    feature_pkg::feature_t wr_data;
    logic rd_busy;
    feature_pkg::feature_addr_t rd_addr;

    always_comb
    begin
        case (hdr_cnt)
            3'd0: hdr_addr = feature_pkg::ADDR_HEIGHT;
            3'd1: hdr_addr = feature_pkg::ADDR_WIDTH;
            3'd2: hdr_addr = feature_pkg::ADDR_LENGTH;
            3'd3: hdr_addr = feature_pkg::ADDR_POINTS_NORM;
            default: hdr_addr = feature_pkg::ADDR_MEAN_INTENSITY;
        endcase
    end

    // header writes own the port while they run
    assign wr_en = hdr_busy || slice_wr_en;
    assign wr_addr = hdr_busy ? hdr_addr : slice_wr_addr;
    assign wr_data = hdr_busy ? hdr_q[hdr_cnt] : slice_wr_data;

    always_ff @(posedge clk)
    begin
        if (flag_valid_header)
        begin
            hdr_q[0] <= h_in;
            hdr_q[1] <= w_in;
            hdr_q[2] <= l_in;
            hdr_q[3] <= num_points_norm_in;
            hdr_q[4] <= mean_intensity_in;
        end
    end

    // five writes on the cycles after the header
    always_ff @(posedge clk)
    begin
        if (flag_reset)
        begin
            hdr_busy <= 1'b0;
            hdr_cnt <= '0;
        end
        else if (flag_valid_header)
        begin
            hdr_busy <= 1'b1;
            hdr_cnt <= '0;
        end
        else if (hdr_busy)
        begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == 3'd4)
            begin
                hdr_busy <= 1'b0;
            end
        end
    end

    // single write, single registered read
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            feature_mem[wr_addr] <= wr_data;
        end
        features <= feature_mem[rd_addr];
    end

    // readout sweep 0..14, data one cycle behind the address
    always_ff @(posedge clk)
    begin
        if (flag_reset)
        begin
            rd_busy <= 1'b0;
            rd_addr <= '0;
            flag_valid_out <= 1'b0;
        end
        else
        begin
            flag_valid_out <= rd_busy;
            if (flag_norm_done)
            begin
                rd_busy <= 1'b1;
                rd_addr <= '0;
            end
            else if (rd_busy)
            begin
                if (rd_addr == feature_pkg::FEATURE_DEPTH - 1)
                begin
                    rd_busy <= 1'b0;
                end
                else
                begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    // a new header would overwrite words still being read
    a_no_header_in_readout: assert property (
        @(posedge clk) disable iff (flag_reset) flag_valid_header |-> !rd_busy
    );

endmodule

// File: src/slice_normalizer.sv
module slice_normalizer (
    input  logic                       clk,
    input  logic                       flag_reset,
    input  logic                       flag_valid_header,
    input  feature_pkg::count_t        num_points,
    input  feature_pkg::count_t        slice_counts [feature_pkg::SLICE_COUNT],
    input  logic                       flag_counts_ready,
    output logic                       slice_wr_en,
    output feature_pkg::feature_addr_t slice_wr_addr,
    output feature_pkg::feature_t      slice_wr_data,
    output logic                       flag_norm_done
);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_DIV} state_t;

    state_t state;
    feature_pkg::count_t num_points_q;
    logic [3:0] slice_idx;
    logic [3:0] bit_cnt;
    // partial remainder
    feature_pkg::count_t rem;
    // low dividend bits shift out, quotient bits shift in
    feature_pkg::feature_t quo;
    logic [26:0] dividend;
    logic [11:0] partial;
    logic [11:0] diff;
    logic fits;
    feature_pkg::feature_t quo_next;

    // count scaled up to the ratio fraction
    assign dividend = 27'(slice_counts[slice_idx]) << feature_pkg::RATIO_FRAC_BITS;

    // one restoring step
    assign partial = {rem, quo[15]};
    assign diff = partial - {1'b0, num_points_q};
    assign fits = partial >= {1'b0, num_points_q};
    assign quo_next = {quo[14:0], fits};

    always_ff @(posedge clk)
    begin
        if (flag_reset)
        begin
            state <= S_IDLE;
            slice_idx <= '0;
            bit_cnt <= '0;
            slice_wr_en <= 1'b0;
            flag_norm_done <= 1'b0;
        end
        else
        begin
            slice_wr_en <= 1'b0;
            flag_norm_done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (flag_counts_ready)
                    begin
                        slice_idx <= '0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD:
                begin
                    bit_cnt <= '0;
                    state <= S_DIV;
                end
                S_DIV:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    // 16 quotient bits done, write this slice
                    if (bit_cnt == 4'd15)
                    begin
                        slice_wr_en <= 1'b1;
                        if (slice_idx == feature_pkg::SLICE_COUNT - 1)
                        begin
                            flag_norm_done <= 1'b1;
                            state <= S_IDLE;
                        end
                        else
                        begin
                            slice_idx <= slice_idx + 1'b1;
                            state <= S_LOAD;
                        end
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (flag_valid_header)
        begin
            num_points_q <= num_points;
        end
        if (state == S_LOAD)
        begin
            rem <= dividend[26:16];
            quo <= dividend[15:0];
        end
        else if (state == S_DIV)
        begin
            rem <= fits ? diff[10:0] : partial[10:0];
            quo <= quo_next;
        end
        if (state == S_DIV && bit_cnt == 4'd15)
        begin
            slice_wr_addr <= feature_pkg::ADDR_SLICE_BASE + slice_idx;
            // empty cluster gives zero ratios
            slice_wr_data <= (num_points_q == '0) ? '0 : quo_next;
        end
    end

    // next cluster may only end after this one is stored
    a_ready_when_idle: assert property (
        @(posedge clk) disable iff (flag_reset) flag_counts_ready |-> state == S_IDLE
    );

endmodule

// File: src/slice_counter.sv
module slice_counter (
    input  logic                clk,
    input  logic                flag_reset,
    input  logic                flag_valid_header,
    input  feature_pkg::fixed_t z_min,
    input  feature_pkg::fixed_t z,
    input  logic                flag_point_valid,
    input  logic                flag_points_done,
    input  logic                flag_norm_done,
    output feature_pkg::count_t slice_counts [feature_pkg::SLICE_COUNT],
    output logic                flag_counts_ready
);

    feature_pkg::fixed_t z_min_q;
    // upper edge of every slice
    feature_pkg::fixed_t slice_bound [feature_pkg::SLICE_COUNT];
    feature_pkg::slice_mask_t slice_hit;

    // boundaries fixed for the whole cluster
    always_ff @(posedge clk)
    begin
        if (flag_valid_header)
        begin
            z_min_q <= z_min;
            for (int k = 0; k < feature_pkg::SLICE_COUNT; k++)
            begin
                slice_bound[k] <= z_min + feature_pkg::SLICE_HEIGHT[k];
            end
        end
    end

    for (genvar k = 0; k < feature_pkg::SLICE_COUNT; k++)
    begin : g_slice
        feature_pkg::fixed_t lower;

        // slice 0 starts at z_min, the rest at the edge below
        if (k == 0)
        begin : g_first
            assign lower = z_min_q;
        end
        else
        begin : g_upper
            assign lower = slice_bound[k-1];
        end

        // half open interval, above the top edge hits nothing
        assign slice_hit[k] = flag_point_valid && (z >= lower) && (z < slice_bound[k]);
    end

    // counts cleared once the ratios are stored
    always_ff @(posedge clk)
    begin
        if (flag_reset || flag_norm_done)
        begin
            for (int k = 0; k < feature_pkg::SLICE_COUNT; k++)
            begin
                slice_counts[k] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < feature_pkg::SLICE_COUNT; k++)
            begin
                if (slice_hit[k])
                begin
                    slice_counts[k] <= slice_counts[k] + 1'b1;
                end
            end
        end
    end

    // last point lands the cycle before the done pulse
    assign flag_counts_ready = flag_points_done;

    // bounds from the header must keep slices disjoint
    a_slice_hit_onehot: assert property (
        @(posedge clk) disable iff (flag_reset) $onehot0(slice_hit)
    );

endmodule

// File: src/point_height_calc.sv
module point_height_calc (
    input  logic                  clk,
    input  logic                  flag_reset,
    input  logic                  flag_new_points,
    input  feature_pkg::feature_t distance,
    input  feature_pkg::laser_t   laser,
    output feature_pkg::fixed_t   z,
    output logic                  flag_point_valid,
    output logic                  flag_points_done
);

    logic [31:0] dist_prod;
    // distance in metres, 6c10f
    logic [15:0] dist_m_q;
    logic signed [11:0] sin_q;
    // s7c20f product
    logic signed [28:0] z_prod;
    feature_pkg::fixed_t z_raw_q;
    logic valid_s1;
    logic valid_s2;
    logic new_points_q;
    logic [feature_pkg::HEIGHT_LATENCY-1:0] done_pipe;

    // code times 0.002, 16 fraction bits
    assign dist_prod = distance * feature_pkg::DIST_SCALE;
    // distance is unsigned, so pad a zero sign bit
    assign z_prod = $signed({1'b0, dist_m_q}) * sin_q;

    // valid and end of stream travel with the data
    always_ff @(posedge clk)
    begin
        if (flag_reset)
        begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            flag_point_valid <= 1'b0;
            new_points_q <= 1'b0;
            done_pipe <= '0;
        end
        else
        begin
            valid_s1 <= flag_new_points;
            valid_s2 <= valid_s1;
            // drop points on or under the ground
            flag_point_valid <= valid_s2 && (z_raw_q > feature_pkg::GROUND_LIMIT);
            new_points_q <= flag_new_points;
            // falling edge of the stream
            done_pipe <= {done_pipe[feature_pkg::HEIGHT_LATENCY-2:0],
                          new_points_q & ~flag_new_points};
        end
    end

    // stage 1 scale and sine lookup
    // stage 2 product, stage 3 output
    always_ff @(posedge clk)
    begin
        dist_m_q <= dist_prod[21:6];
        sin_q <= feature_pkg::SIN_THETA[laser];
        z_raw_q <= z_prod[26:11];
        z <= z_raw_q;
    end

    assign flag_points_done = done_pipe[feature_pkg::HEIGHT_LATENCY-1];

endmodule

// File: src/feature_pkg.sv
package feature_pkg;

    // s6c9f height or coordinate
    typedef logic signed [15:0] fixed_t;
    // one word of the feature vector
    typedef logic [15:0] feature_t;
    // points per cluster or per slice
    typedef logic [10:0] count_t;
    typedef logic [5:0] laser_t;
    typedef logic [3:0] feature_addr_t;
    // one bit per horizontal slice
    typedef logic [9:0] slice_mask_t;

    localparam int SLICE_COUNT = 10;
    localparam int FEATURE_DEPTH = 15;
    localparam int HEIGHT_LATENCY = 3;
    // slice ratio is count / num_points with 15 fraction bits
    localparam int RATIO_FRAC_BITS = 15;

    // 0.002 m per distance code, 16 fraction bits
    localparam logic [15:0] DIST_SCALE = 16'd131;

    // -6 m, anything at or below is ground
    localparam fixed_t GROUND_LIMIT = -16'sd3072;

    // sin of vertical angle per laser, s1c10f
    // laser 0 at -24.8 deg, 0.4 deg per laser
    localparam logic signed [11:0] SIN_THETA [64] = '{
        -12'sd430, -12'sd423, -12'sd416, -12'sd410, -12'sd403, -12'sd397, -12'sd390, -12'sd384,
        -12'sd377, -12'sd370, -12'sd364, -12'sd357, -12'sd350, -12'sd344, -12'sd337, -12'sd330,
        -12'sd323, -12'sd316, -12'sd310, -12'sd303, -12'sd296, -12'sd289, -12'sd282, -12'sd275,
        -12'sd268, -12'sd262, -12'sd255, -12'sd248, -12'sd241, -12'sd234, -12'sd227, -12'sd220,
        -12'sd213, -12'sd206, -12'sd199, -12'sd192, -12'sd185, -12'sd178, -12'sd171, -12'sd164,
        -12'sd157, -12'sd150, -12'sd143, -12'sd135, -12'sd128, -12'sd121, -12'sd114, -12'sd107,
        -12'sd100, -12'sd93,  -12'sd86,  -12'sd79,  -12'sd71,  -12'sd64,  -12'sd57,  -12'sd50,
        -12'sd43,  -12'sd36,  -12'sd29,  -12'sd21,  -12'sd14,  -12'sd7,   12'sd0,    12'sd7
    };

    // upper edge of each slice above z_min, 9 fraction bits
    // roughly 0.2 m steps up to 2 m
    localparam fixed_t SLICE_HEIGHT [SLICE_COUNT] = '{
        16'sd102, 16'sd205, 16'sd307, 16'sd410, 16'sd512,
        16'sd614, 16'sd717, 16'sd819, 16'sd922, 16'sd1024
    };

    // feature memory map
    localparam feature_addr_t ADDR_HEIGHT = 4'd0;
    localparam feature_addr_t ADDR_WIDTH = 4'd1;
    localparam feature_addr_t ADDR_LENGTH = 4'd2;
    localparam feature_addr_t ADDR_POINTS_NORM = 4'd3;
    // slice ratios sit at 4..13
    localparam feature_addr_t ADDR_SLICE_BASE = 4'd4;
    localparam feature_addr_t ADDR_MEAN_INTENSITY = 4'd14;

endpackage
